/* spr_line_params.svh */
/*
 * Size constants for the object line-buffer subsystem.
 * Include in any file that needs table, slot or raster sizes.
 */

`ifndef SPR_LINE_PARAMS_SVH
`define SPR_LINE_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// object table
`define SPR_NUM_OBJ 32          // entries in the host object table.
`define SPR_OBJ_W   29          // en, vflip, hflip, color, code, x, y.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line buffer, one slot per 4 pixels
`define SPR_SLOTS   64          // slots per line.
`define SPR_SLOT_W  18          // packed slot entry.

// raster, in cen steps and lines
`define SPR_H_TOTAL 256         // cen steps per line.
`define SPR_V_TOTAL 256         // lines per frame.

`endif

/* obj_pkg.sv */
/*
 * Object table entry, line slot entry and scanner states.
 * Import wherever object data is unpacked or the scanner state is shown.
 */

package obj_pkg;

    // one host table entry, 29 bits.
    typedef struct packed {
        logic       enable;     // object drawn when set.
        logic       vflip;      // row order reversed.
        logic       hflip;      // passed through to the slot.
        logic [1:0] color;      // palette select.
        logic [7:0] code;       // pattern number.
        logic [7:0] x;          // [7:2] slot, [1:0] fine offset.
        logic [7:0] y;          // top line, fed to the vertical adder.
    } obj_entry_t;

    // one line buffer slot, 18 bits.
    typedef struct packed {
        logic       valid;      // zero after the clear pass.
        logic       hflip;
        logic [1:0] color;
        logic [7:0] code;
        logic [3:0] row;        // row inside the 16 line object.
        logic [1:0] xfine;      // pixel offset inside the slot.
    } slot_entry_t;

    // scanner phases within a line.
    typedef enum logic [1:0] {
        SCAN_IDLE, SCAN_CLEAR, SCAN_READ, SCAN_WRITE
    } scan_state_e;

endpackage

/* video_pkg.sv */
/*
 * Raster position types and the line bank select.
 * Import into any block that looks at the H/V counters.
 */

`include "spr_line_params.svh"

package video_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // raster counters
    // h counts cen steps across a line.
    typedef logic [$clog2(`SPR_H_TOTAL)-1:0] h_count_t;

    // v counts lines, bit 0 picks the ping-pong bank.
    typedef logic [$clog2(`SPR_V_TOTAL)-1:0] v_count_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // line banks
    // the bank being scanned out on the current line.
    // the other one is cleared and filled for the next line.
    typedef enum logic {
        BANK0 = 1'b0,   // scanned on even lines.
        BANK1 = 1'b1    // scanned on odd lines.
    } line_bank_e;

endpackage

/* line_ram.sv */
/*
 * Single port synchronous RAM with clock enable.
 * One instance per line bank, read registered on every cen.
 */

`timescale 1ns/10ps

module line_ram #(
    parameter int aw = 6,           // address width.
    parameter int dw = 18           // data width.
) (
    input  logic          clk,
    input  logic          cen,
    input  logic [aw-1:0] addr,
    input  logic [dw-1:0] data,
    input  logic          we,
    output logic [dw-1:0] q
);

    logic [dw-1:0] mem [0:(1<<aw)-1];   // contents unknown until cleared.

    always_ff @(posedge clk) begin
        if (cen) begin
            if (we) mem[addr] <= data;
            q <= mem[addr];             // old data on a write cycle.
        end
    end

endmodule

/* video_timing.sv */
/*
 * Pixel clock enable and raster counters.
 * cen is high every second clk, h and v step on it.
 */

`timescale 1ns/10ps

`include "spr_line_params.svh"

module video_timing
    import video_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    output logic     cen,
    output h_count_t h,
    output v_count_t v
);

    logic h_last;   // last step of the line.
    logic v_last;   // last line of the frame.

    assign h_last = (h == h_count_t'(`SPR_H_TOTAL - 1));
    assign v_last = (v == v_count_t'(`SPR_V_TOTAL - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // clock enable, divide by two
    always_ff @(posedge clk) begin
        if (!rst_n) cen <= 1'b0;
        else        cen <= ~cen;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // raster counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h <= '0;
            v <= '0;
        end else if (cen) begin
            if (h_last) begin
                h <= '0;                        // wrap the line.
                if (v_last) v <= '0;            // new frame.
                else        v <= v + 1'b1;
            end else begin
                h <= h + 1'b1;
            end
        end
    end

    // v moves at the same edge as h wraps,
    // so every step of a line sees one stable v.

endmodule

/* obj_scanner.sv */
/*
 * Host object table and per line scanner.
 * Clears the idle bank, then walks the table and strobes each enabled entry
 * out to the line buffer, which does the range test.
 */

`timescale 1ns/10ps

`include "spr_line_params.svh"

module obj_scanner
    import video_pkg::*, obj_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cen,
    input  h_count_t                         h,
    // host write port
    input  logic                             obj_we,
    input  logic [$clog2(`SPR_NUM_OBJ)-1:0]  obj_addr,
    input  logic [`SPR_OBJ_W-1:0]            obj_wdata,
    // to the line buffer
    output logic [`SPR_OBJ_W-1:0]            obj_data,
    output logic                             clr,
    output logic [$clog2(`SPR_SLOTS)-1:0]    wr_slot,
    output logic                             wr_strobe
);

    localparam int SLOT_AW = $clog2(`SPR_SLOTS);
    localparam int OBJ_AW  = $clog2(`SPR_NUM_OBJ);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // object table
    // enable bits live apart so reset can clear them.
    logic [`SPR_OBJ_W-2:0]   table_mem [0:`SPR_NUM_OBJ-1];  // all fields but enable.
    logic [`SPR_NUM_OBJ-1:0] en_vec;
    obj_entry_t              wdata_e;

    assign wdata_e = obj_entry_t'(obj_wdata);

    always_ff @(posedge clk) begin
        if (obj_we) table_mem[obj_addr] <= obj_wdata[`SPR_OBJ_W-2:0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n)      en_vec <= '0;                         // table starts empty.
        else if (obj_we) en_vec[obj_addr] <= wdata_e.enable;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scan FSM
    // steps 0..63 clear, 64..127 read/write pairs, then idle.
    scan_state_e        state;
    logic [SLOT_AW-1:0] step_cnt;   // slot in clear, object in walk.
    obj_entry_t         obj_reg;    // entry latched by the read step.
    logic [OBJ_AW-1:0]  obj_idx;
    logic               line_wrap;

    assign obj_idx   = step_cnt[OBJ_AW-1:0];
    assign line_wrap = (h == h_count_t'(`SPR_H_TOTAL - 1));   // h goes to 0 next.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= SCAN_IDLE;
            step_cnt <= '0;
        end else if (cen) begin
            if (line_wrap) begin
                state    <= SCAN_CLEAR;     // restart every line.
                step_cnt <= '0;
            end else begin
                case (state)
                    SCAN_CLEAR: begin
                        if (step_cnt == SLOT_AW'(`SPR_SLOTS - 1)) begin
                            state    <= SCAN_READ;
                            step_cnt <= '0;
                        end else begin
                            step_cnt <= step_cnt + 1'b1;
                        end
                    end
                    SCAN_READ:  state <= SCAN_WRITE;
                    SCAN_WRITE: begin
                        if (obj_idx == OBJ_AW'(`SPR_NUM_OBJ - 1)) begin
                            state <= SCAN_IDLE;     // walk done.
                        end else begin
                            state    <= SCAN_READ;
                            step_cnt <= step_cnt + 1'b1;
                        end
                    end
                    default: state <= SCAN_IDLE;
                endcase
            end
        end
    end

    // table read, entry held through the write step.
    always_ff @(posedge clk) begin
        if (cen && state == SCAN_READ) begin
            obj_reg <= obj_entry_t'({en_vec[obj_idx], table_mem[obj_idx]});
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // outputs to the buffer
    assign obj_data  = obj_reg;
    assign clr       = (state == SCAN_CLEAR);
    assign wr_slot   = clr ? step_cnt : obj_reg.x[7:2];  // upper six x bits.
    assign wr_strobe = cen & (clr | (state == SCAN_WRITE && obj_reg.enable));

endmodule

/* obj_line_buf.sv */
/*
 * Ping-pong object line buffer.
 * Range tests each strobed object for the next line, writes it to the idle
 * bank and streams the scanned bank out one slot per 4 cen steps.
 */

`timescale 1ns/10ps

`include "spr_line_params.svh"

module obj_line_buf
    import video_pkg::*, obj_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cen,
    input  h_count_t                      h,
    input  v_count_t                      v,
    // from the scanner
    input  logic [`SPR_OBJ_W-1:0]         obj_data,
    input  logic                          clr,
    input  logic [$clog2(`SPR_SLOTS)-1:0] wr_slot,
    input  logic                          wr_strobe,
    // slot stream
    output logic                          slot_strobe,
    output v_count_t                      slot_line,
    output logic [$clog2(`SPR_SLOTS)-1:0] slot_index,
    output logic                          slot_valid,
    output logic                          slot_hflip,
    output logic [1:0]                    slot_color,
    output logic [7:0]                    slot_code,
    output logic [3:0]                    slot_row,
    output logic [1:0]                    slot_xfine
);

    localparam int SLOT_AW = $clog2(`SPR_SLOTS);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // vertical adder
    obj_entry_t  obj;
    logic [7:0]  vsum;      // y + v + 1, the line being built.
    logic        in_range;
    slot_entry_t ram_din;

    assign obj      = obj_entry_t'(obj_data);
    assign vsum     = obj.y + v + 8'd1;
    assign in_range = (vsum[7:4] == 4'hf);         // 16 lines tall.

    always_comb begin
        ram_din = '0;                               // clear pass writes empty slots.
        if (!clr) begin
            ram_din.valid = 1'b1;
            ram_din.hflip = obj.hflip;
            ram_din.color = obj.color;
            ram_din.code  = obj.code;
            ram_din.row   = vsum[3:0] ^ {4{obj.vflip}};
            ram_din.xfine = obj.x[1:0];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bank select
    line_bank_e         scan_bank;
    logic               wr_ok;
    logic               we0, we1;
    logic [SLOT_AW-1:0] scan_addr, addr0, addr1;
    logic [`SPR_SLOT_W-1:0] q0, q1;

    assign scan_bank = line_bank_e'(v[0]);
    assign scan_addr = h[7:2];                      // one slot per 4 steps.
    assign wr_ok     = clr | in_range;

    assign we0   = wr_strobe & wr_ok & (scan_bank == BANK1);   // bank 0 idle.
    assign we1   = wr_strobe & wr_ok & (scan_bank == BANK0);
    assign addr0 = (scan_bank == BANK0) ? scan_addr : wr_slot;
    assign addr1 = (scan_bank == BANK1) ? scan_addr : wr_slot;

    line_ram #(.aw(SLOT_AW), .dw(`SPR_SLOT_W)) u_ram0 (
        .clk  (clk),
        .cen  (cen),
        .addr (addr0),
        .data (ram_din),
        .we   (we0),
        .q    (q0)
    );

    line_ram #(.aw(SLOT_AW), .dw(`SPR_SLOT_W)) u_ram1 (
        .clk  (clk),
        .cen  (cen),
        .addr (addr1),
        .data (ram_din),
        .we   (we1),
        .q    (q1)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output register, loads on the last step of each slot
    logic        slot_load;
    slot_entry_t slot_reg;

    assign slot_load = cen && (h[1:0] == 2'b11);

    always_ff @(posedge clk) begin
        if (!rst_n) slot_strobe <= 1'b0;
        else        slot_strobe <= slot_load;       // one clk wide.
    end

    always_ff @(posedge clk) begin
        if (slot_load) begin
            slot_reg   <= slot_entry_t'((scan_bank == BANK0) ? q0 : q1);
            slot_index <= scan_addr;
            slot_line  <= v;
        end
    end

    assign slot_valid = slot_reg.valid;
    assign slot_hflip = slot_reg.hflip;
    assign slot_color = slot_reg.color;
    assign slot_code  = slot_reg.code;
    assign slot_row   = slot_reg.row;
    assign slot_xfine = slot_reg.xfine;

endmodule

/* spr_line_top.sv */
/*
 * Object line buffer subsystem top level.
 * Host writes the object table and a slot stream comes out per line.
 */

`timescale 1ns/10ps

`include "spr_line_params.svh"

module spr_line_top
    import video_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    // host table write
    input  logic                            obj_we,
    input  logic [$clog2(`SPR_NUM_OBJ)-1:0] obj_addr,
    input  logic [`SPR_OBJ_W-1:0]           obj_wdata,
    // slot stream
    output logic                            slot_strobe,
    output v_count_t                        slot_line,
    output logic [$clog2(`SPR_SLOTS)-1:0]   slot_index,
    output logic                            slot_valid,
    output logic                            slot_hflip,
    output logic [1:0]                      slot_color,
    output logic [7:0]                      slot_code,
    output logic [3:0]                      slot_row,
    output logic [1:0]                      slot_xfine
);

    logic                          cen;
    h_count_t                      h;
    v_count_t                      v;
    logic [`SPR_OBJ_W-1:0]         obj_data;    // entry under test.
    logic                          clr;
    logic [$clog2(`SPR_SLOTS)-1:0] wr_slot;
    logic                          wr_strobe;

    video_timing u_timing (.clk(clk), .rst_n(rst_n), .cen(cen), .h(h), .v(v));

    obj_scanner u_scanner (
        .clk(clk), .rst_n(rst_n), .cen(cen), .h(h),
        .obj_we(obj_we), .obj_addr(obj_addr), .obj_wdata(obj_wdata),
        .obj_data(obj_data), .clr(clr), .wr_slot(wr_slot), .wr_strobe(wr_strobe)
    );

    obj_line_buf u_buf (
        .clk(clk), .rst_n(rst_n), .cen(cen), .h(h), .v(v),
        .obj_data(obj_data), .clr(clr), .wr_slot(wr_slot), .wr_strobe(wr_strobe),
        .slot_strobe(slot_strobe), .slot_line(slot_line), .slot_index(slot_index),
        .slot_valid(slot_valid), .slot_hflip(slot_hflip), .slot_color(slot_color),
        .slot_code(slot_code), .slot_row(slot_row), .slot_xfine(slot_xfine)
    );

endmodule

/* tb_spr_line_tasks.svh */
/*
 * Host write, stream wait and compare tasks for the line buffer testbench.
 * Included inside the testbench module and works on its signals and model table.
 */

`ifndef TB_SPR_LINE_TASKS_SVH
`define TB_SPR_LINE_TASKS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host side and waits
task automatic write_obj(input int idx, input obj_entry_t e);
    @(negedge clk);
    obj_we         = 1'b1;
    obj_addr       = 5'(idx);
    obj_wdata      = e;
    model_tbl[idx] = e;                     // model follows the host write.
    @(negedge clk);
    obj_we = 1'b0;
endtask

task automatic wait_strobe(input string what);
    int n;
    n = 0;
    do begin
        @(negedge clk);                     // strobe is one clk wide, seen here once.
        n++;
    end while (!slot_strobe && n < 64);
    if (!slot_strobe) begin
        $display("timeout: slot strobe stopped during %s", what);
        stop_fail();
    end
endtask

task automatic wait_line(input v_count_t target);
    int n;
    bit hit;
    n   = 0;
    hit = 0;
    while (!hit && n < LINE_WAIT) begin
        @(negedge clk);
        n++;
        hit = slot_strobe && slot_index === 6'd0 && slot_line === target;
    end
    if (!hit) begin
        $display("timeout: line %0d never started on the slot stream", target);
        stop_fail();
    end
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// compares
task automatic check_slot(input string name, input slot_entry_t exp, input slot_entry_t act);
    if (act !== exp) begin
        $display("** Error %s: line %0d slot %0d expected %h actual %h",
                 name, slot_line, slot_index, exp, act);
        stop_fail();
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    if (act !== exp) begin
        $display("** Error %s: expected %0d actual %0d", name, exp, act);
        stop_fail();
    end
endtask

// one whole line of strobes, every slot against the model.
task automatic collect_line(input string name, input v_count_t line, output int hits);
    int          cnt;
    slot_entry_t got;
    cnt  = 0;
    hits = 0;
    wait_line(line);
    do begin
        got = {slot_valid, slot_hflip, slot_color, slot_code, slot_row, slot_xfine};
        check_count({name, " index"}, cnt, int'(slot_index));
        check_slot(name, expected_slot(line, cnt), got);
        hits += got.valid;
        cnt++;
        if (cnt < `SPR_SLOTS) wait_strobe(name);
    end while (cnt < `SPR_SLOTS && slot_line == line);
    check_count({name, " strobes"}, `SPR_SLOTS, cnt);
endtask

`endif

/* tb_spr_line.sv */
/*
 * Directed testbench for the object line buffer subsystem.
 * Writes the object table through the host port and checks every slot of
 * the stream against a model of the range and priority rules.
 */

`timescale 1ns/10ps

`include "spr_line_params.svh"

module tb_spr_line
    import video_pkg::*, obj_pkg::*;
();

    localparam int LINE_WAIT = 4 * `SPR_H_TOTAL * `SPR_V_TOTAL;  // two frames of clk.

    logic                  clk;
    logic                  rst_n;
    logic                  obj_we;
    logic [4:0]            obj_addr;
    logic [`SPR_OBJ_W-1:0] obj_wdata;
    logic                  slot_strobe;
    v_count_t              slot_line;
    logic [5:0]            slot_index;
    logic                  slot_valid;
    logic                  slot_hflip;
    logic [1:0]            slot_color;
    logic [7:0]            slot_code;
    logic [3:0]            slot_row;
    logic [1:0]            slot_xfine;

    obj_entry_t model_tbl [0:`SPR_NUM_OBJ-1];   // host view of the table.
    integer     seed;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns period.
    end

    spr_line_top dut0 (
        .clk(clk), .rst_n(rst_n), .obj_we(obj_we), .obj_addr(obj_addr),
        .obj_wdata(obj_wdata), .slot_strobe(slot_strobe), .slot_line(slot_line),
        .slot_index(slot_index), .slot_valid(slot_valid), .slot_hflip(slot_hflip),
        .slot_color(slot_color), .slot_code(slot_code), .slot_row(slot_row),
        .slot_xfine(slot_xfine)
    );

    `include "tb_spr_line_tasks.svh"

    task automatic stop_fail();
        scan_state_e st;
        st = dut0.u_scanner.state;              // where the scanner was, for debug.
        $display("scanner in %s at %0t", st.name(), $time);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    function automatic obj_entry_t pack_obj(input logic en, input logic vf, input logic hf,
                                            input logic [1:0] color, input logic [7:0] code,
                                            input logic [7:0] x, input logic [7:0] y);
        return obj_entry_t'({en, vf, hf, color, code, x, y});
    endfunction

    // slot seen on line L comes from the scan of L-1, so y + (L-1) + 1.
    function automatic slot_entry_t expected_slot(input v_count_t line, input int idx);
        slot_entry_t s;
        obj_entry_t  e;
        logic [7:0]  vsum;
        s = '0;
        for (int i = 0; i < `SPR_NUM_OBJ; i++) begin
            e    = model_tbl[i];
            vsum = e.y + line;
            if (e.enable && e.x[7:2] == 6'(idx) && vsum[7:4] == 4'hf) begin
                s = {1'b1, e.hflip, e.color, e.code, vsum[3:0] ^ {4{e.vflip}}, e.x[1:0]};
            end                                 // later entry overwrites.
        end
        return s;
    endfunction

    // n_lines lines from first, exp_hits valid slots in total (negative skips it).
    task automatic check_lines(input string name, input v_count_t first,
                               input int n_lines, input int exp_hits);
        int total;
        int hits;
        total = 0;
        for (int k = 0; k < n_lines; k++) begin
            collect_line(name, v_count_t'(first + k), hits);
            total += hits;
        end
        if (exp_hits >= 0) check_count({name, " hits"}, exp_hits, total);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests, each one starts where the last one left the raster
    task automatic empty_table();
        check_lines("empty", 8'd2, 8, 0);       // lines 0 and 1 read uncleared RAM.
    endtask

    task automatic single_object();
        write_obj(0, pack_obj(1'b1, 1'b0, 1'b0, 2'd1, 8'h3c, 8'd45, 8'd200));
        check_lines("single", 8'd36, 24, 16);   // in range on lines 40..55.
    endtask

    task automatic flip_bits();
        write_obj(0, pack_obj(1'b1, 1'b1, 1'b1, 2'd3, 8'ha5, 8'd130, 8'd160));
        check_lines("flip", 8'd76, 24, 16);     // rows 15 down to 0 on 80..95.
    endtask

    task automatic slot_priority();
        write_obj(2, pack_obj(1'b1, 1'b0, 1'b0, 2'd0, 8'h11, 8'd64, 8'd120));
        write_obj(5, pack_obj(1'b1, 1'b0, 1'b1, 2'd2, 8'h22, 8'd66, 8'd120));
        write_obj(9, pack_obj(1'b1, 1'b0, 1'b0, 2'd1, 8'h33, 8'd200, 8'd120));
        check_lines("priority", 8'd116, 24, 32); // entry 5 owns slot 16, 9 owns 50.
    endtask

    task automatic disable_entry();
        write_obj(3, pack_obj(1'b1, 1'b0, 1'b0, 2'd1, 8'h44, 8'd12, 8'd96));
        check_lines("disable on", 8'd142, 4, 2);
        write_obj(3, pack_obj(1'b0, 1'b0, 1'b0, 2'd1, 8'h44, 8'd12, 8'd96));
        check_lines("disable off", 8'd149, 8, 0);   // would be in range up to 159.
    endtask

    task automatic random_frame();
        logic [31:0] r;
        for (int i = 0; i < `SPR_NUM_OBJ; i++) begin
            r = $random(seed);
            write_obj(i, obj_entry_t'(r[`SPR_OBJ_W-1:0]));
        end
        check_lines("random", 8'd159, `SPR_V_TOTAL, -1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        rst_n     = 1'b0;
        obj_we    = 1'b0;
        obj_addr  = '0;
        obj_wdata = '0;
        seed      = 32'h75dd_406e;
        for (int i = 0; i < `SPR_NUM_OBJ; i++) model_tbl[i] = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        empty_table();
        single_object();
        flip_bits();
        slot_priority();
        disable_entry();
        random_frame();
        $display("TB PASSED");
        $finish;
    end

endmodule

/* spr_line.f */
+incdir+.
obj_pkg.sv
video_pkg.sv
line_ram.sv
video_timing.sv
obj_scanner.sv
obj_line_buf.sv
spr_line_top.sv
tb_spr_line.sv
